// ==== src.f ====
glb_cfg_pkg.sv
glb_cfg_ingress.sv
glb_tile_cfg.sv
glb_cfg_egress.sv
glb_cfg_top.sv
tb_glb_cfg.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_glb_cfg
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass search, not from the simulator
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_glb_cfg.sv ====
// testbench that runs the tile config chain against a shadow register model
`timescale 1ns/100ps
`default_nettype none

module tb_glb_cfg;

    import glb_cfg_pkg::*;

    localparam int NUM_TILES   = 4;
    localparam int QUEUE_DEPTH = 2;
    localparam int CLK_PERIOD  = 20;
    localparam int READ_LAT    = NUM_TILES + 2;
    // every op of every test fits in one read latency
    localparam int TEST_OPS    = 2 * NUM_TILES * 11 + 2 * NUM_TILES + 3 * NUM_TILES + 16 + 16;
    localparam int TIMEOUT_NS  = TEST_OPS * READ_LAT * CLK_PERIOD + 2000;

    logic                                         clk;
    logic                                         arst_n;
    logic                                         wr_en;
    logic                                         rd_en;
    logic [CFG_ADDR_WIDTH-1:0]                    addr;
    logic [CFG_DATA_WIDTH-1:0]                    wr_data;
    logic                                         rd_done;
    logic [CFG_DATA_WIDTH-1:0]                    rd_data;
    logic                                         rd_nack;
    logic [NUM_TILES*QUEUE_DEPTH-1:0]             st_invalidate;
    logic [NUM_TILES*QUEUE_DEPTH-1:0]             ld_invalidate;
    tile_ctrl_t [NUM_TILES-1:0]                   tile_ctrl;
    logic [NUM_TILES-1:0][3:0]                    latency;
    dma_header_t [NUM_TILES-1:0][QUEUE_DEPTH-1:0] st_header;
    dma_header_t [NUM_TILES-1:0][QUEUE_DEPTH-1:0] ld_header;

    // shadow copy of every tile register
    tile_ctrl_t [NUM_TILES-1:0]                   ctrl_m;
    logic [NUM_TILES-1:0][3:0]                    lat_m;
    dma_header_t [NUM_TILES-1:0][QUEUE_DEPTH-1:0] st_m;
    dma_header_t [NUM_TILES-1:0][QUEUE_DEPTH-1:0] ld_m;

    logic [32:0] exp_q [$];   // {nack, data} per outstanding read
    int          issue_q [$];
    int          cyc;
    int          pass_cnt;
    int          fail_cnt;
    int          fail_mark;
    integer      seed;

    glb_cfg_top #(
        .NUM_TILES   (NUM_TILES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) pass_cnt++;
        else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_cnt++;
        end
    endtask

    task automatic check_outputs();
        for (int t = 0; t < NUM_TILES; t++) begin
            check_val($sformatf("tile_ctrl[%0d]", t), 64'(tile_ctrl[t]), 64'(ctrl_m[t]));
            check_val($sformatf("latency[%0d]", t), 64'(latency[t]), 64'(lat_m[t]));
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                check_val($sformatf("st_header[%0d][%0d]", t, q), 64'(st_header[t][q]),
                          64'(st_m[t][q]));
                check_val($sformatf("ld_header[%0d][%0d]", t, q), 64'(ld_header[t][q]),
                          64'(ld_m[t][q]));
            end
        end
    endtask

    function automatic logic [CFG_ADDR_WIDTH-1:0] make_addr(int t, int r);
        return {TILE_ID_WIDTH'(t), REG_ID_WIDTH'(r)};
    endfunction

    // register map applied to the shadow copy
    function automatic void model_write(int t, int r, logic [31:0] d);
        case (r)
            0: begin
                ctrl_m[t].tile_connected = d[0];
                ctrl_m[t].strm_g2f_mux   = d[2:1];
                ctrl_m[t].strm_f2g_mux   = d[4:3];
                ctrl_m[t].ld_dma_mode    = d[6:5];
                ctrl_m[t].st_dma_mode    = d[8:7];
            end
            1: lat_m[t] = d[3:0];
            2: st_m[t][0].start_addr = d[21:0];
            3: st_m[t][0].num_words  = d[20:0];
            4: st_m[t][1].start_addr = d[21:0];
            5: st_m[t][1].num_words  = d[20:0];
            6: ld_m[t][0].start_addr = d[21:0];
            7: ld_m[t][0].num_words  = d[20:0];
            8: ld_m[t][1].start_addr = d[21:0];
            9: ld_m[t][1].num_words  = d[20:0];
            10: begin
                for (int q = 0; q < QUEUE_DEPTH; q++) begin
                    if (d[q]) st_m[t][q].valid = 1'b1;   // zeros leave valid alone
                    if (d[2 + q]) ld_m[t][q].valid = 1'b1;
                end
            end
            default: ;
        endcase
    endfunction

    function automatic logic [32:0] model_read(int t, int r);
        logic [31:0] d;
        d = '0;
        if (t >= NUM_TILES) return {1'b1, 32'h0};
        case (r)
            0: d = {23'h0, ctrl_m[t].st_dma_mode, ctrl_m[t].ld_dma_mode,
                    ctrl_m[t].strm_f2g_mux, ctrl_m[t].strm_g2f_mux, ctrl_m[t].tile_connected};
            1: d = {28'h0, lat_m[t]};
            2: d = {10'h0, st_m[t][0].start_addr};
            3: d = {11'h0, st_m[t][0].num_words};
            4: d = {10'h0, st_m[t][1].start_addr};
            5: d = {11'h0, st_m[t][1].num_words};
            6: d = {10'h0, ld_m[t][0].start_addr};
            7: d = {11'h0, ld_m[t][0].num_words};
            8: d = {10'h0, ld_m[t][1].start_addr};
            9: d = {11'h0, ld_m[t][1].num_words};
            10: d = {28'h0, ld_m[t][1].valid, ld_m[t][0].valid, st_m[t][1].valid,
                     st_m[t][0].valid};
            default: return {1'b1, 32'h0};
        endcase
        return {1'b0, d};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // write lands on tile t exactly t+2 edges after the strobe is driven
    task automatic do_write(int t, int r, logic [31:0] d);
        wr_en   = 1'b1;
        addr    = make_addr(t, r);
        wr_data = d;
        next_cycle();
        wr_en = 1'b0;
        repeat (t) next_cycle();
        check_outputs();   // one edge early so nothing has changed yet
        model_write(t, r, d);
        next_cycle();
        check_outputs();
    endtask

    task automatic issue_read(int t, int r);
        exp_q.push_back(model_read(t, r));
        issue_q.push_back(cyc);
        rd_en = 1'b1;
        addr  = make_addr(t, r);
        next_cycle();
        rd_en = 1'b0;
    endtask

    task automatic wait_reads();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < READ_LAT + 4) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("read result missing, %0d reads never saw rd_done", exp_q.size());
            fail_cnt++;
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic end_test(string name);
        $display("test %s finished with %0d failed checks", name, fail_cnt - fail_mark);
        fail_mark = fail_cnt;
    endtask

    // read results come back in order at a fixed latency from the strobe
    always @(negedge clk) begin : read_monitor
        logic [32:0] exp_v;
        int          issued;
        if (arst_n && rd_done) begin
            if (exp_q.size() == 0) begin
                $display("rd_done pulsed with no read outstanding");
                fail_cnt++;
            end else begin
                exp_v  = exp_q.pop_front();
                issued = issue_q.pop_front();
                assert (cyc - issued == READ_LAT) pass_cnt++;
                else begin
                    $display("read issued in cycle %0d came back after %0d cycles, not %0d",
                             issued, cyc - issued, READ_LAT);
                    fail_cnt++;
                end
                check_val("rd_data", 64'(rd_data), 64'(exp_v[31:0]));
                check_val("rd_nack", 64'(rd_nack), 64'(exp_v[32]));
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed          = 32'h8e15c977;
        cyc           = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        fail_mark     = 0;
        clk           = 1'b0;
        arst_n        = 1'b0;
        wr_en         = 1'b0;
        rd_en         = 1'b0;
        addr          = '0;
        wr_data       = '0;
        st_invalidate = '0;
        ld_invalidate = '0;
        ctrl_m        = '0;
        lat_m         = '0;
        st_m          = '0;
        ld_m          = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        check_outputs();
        repeat (2 * READ_LAT) begin
            next_cycle();
            check_val("rd_done", 64'(rd_done), 64'h0);
        end
        end_test("reset_values");

        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r <= 10; r++) do_write(t, r, $random(seed));
        end
        end_test("random_writes");

        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r <= 10; r++) issue_read(t, r);
        end
        for (int t = 0; t < NUM_TILES; t++) issue_read(t, 2);   // different tile each cycle
        for (int t = 0; t < NUM_TILES; t++) issue_read(NUM_TILES - 1 - t, 7);
        wait_reads();
        end_test("read_back");

        for (int t = 0; t < NUM_TILES; t++) begin
            issue_read(t, 11 + t);
            issue_read(t, 15);
        end
        for (int t = NUM_TILES; t < 16; t++) issue_read(t, t % 11);
        wait_reads();
        end_test("unmapped_reads");

        for (int t = 0; t < NUM_TILES; t++) do_write(t, 10, 32'hf);
        st_invalidate[1 * QUEUE_DEPTH + 0] = 1'b1;
        ld_invalidate[1 * QUEUE_DEPTH + 1] = 1'b1;
        ld_invalidate[2 * QUEUE_DEPTH + 1] = 1'b1;
        #(CLK_PERIOD / 4);
        check_outputs();   // still set before the sampling edge
        next_cycle();
        st_invalidate = '0;
        ld_invalidate = '0;
        st_m[1][0].valid = 1'b0;
        ld_m[1][1].valid = 1'b0;
        ld_m[2][1].valid = 1'b0;
        check_outputs();
        // validate to tile 1 meets a clear of its store queue 0 on the same edge
        wr_en   = 1'b1;
        addr    = make_addr(1, 10);
        wr_data = 32'h9;
        next_cycle();
        wr_en = 1'b0;
        next_cycle();
        st_invalidate[1 * QUEUE_DEPTH + 0] = 1'b1;
        next_cycle();
        st_invalidate = '0;
        ld_m[1][1].valid = 1'b1;
        check_outputs();
        issue_read(1, 10);
        issue_read(2, 10);
        wait_reads();
        end_test("validate_invalidate");

        $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== glb_cfg_top.sv ====
// config path top, host ingress then a chain of tile config blocks then egress
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_top #(
    parameter int NUM_TILES   = 4,
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   wr_en,
    input  logic                                   rd_en,
    input  logic [glb_cfg_pkg::CFG_ADDR_WIDTH-1:0] addr,
    input  logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] wr_data,
    output logic                                   rd_done,
    output logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] rd_data,
    output logic                                   rd_nack,
    input  logic [NUM_TILES*QUEUE_DEPTH-1:0]       st_invalidate,
    input  logic [NUM_TILES*QUEUE_DEPTH-1:0]       ld_invalidate,
    output glb_cfg_pkg::tile_ctrl_t [NUM_TILES-1:0] tile_ctrl,
    output logic [NUM_TILES-1:0][3:0]              latency,
    output glb_cfg_pkg::dma_header_t [NUM_TILES-1:0][QUEUE_DEPTH-1:0] st_header,
    output glb_cfg_pkg::dma_header_t [NUM_TILES-1:0][QUEUE_DEPTH-1:0] ld_header
);

    import glb_cfg_pkg::*;

    cfg_pkt_t link [NUM_TILES+1];   // link k feeds tile k

    glb_cfg_ingress u_ingress (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .addr    (addr),
        .wr_data (wr_data),
        .pkt_out (link[0])
    );

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile_cfg #(
            .QUEUE_DEPTH (QUEUE_DEPTH),
            .TILE_ID     (k)
        ) u_tile (
            .clk           (clk),
            .arst_n        (arst_n),
            .pkt_in        (link[k]),
            .pkt_out       (link[k+1]),
            .st_invalidate (st_invalidate[k*QUEUE_DEPTH +: QUEUE_DEPTH]),
            .ld_invalidate (ld_invalidate[k*QUEUE_DEPTH +: QUEUE_DEPTH]),
            .tile_ctrl     (tile_ctrl[k]),
            .latency       (latency[k]),
            .st_header     (st_header[k]),
            .ld_header     (ld_header[k])
        );
    end

    glb_cfg_egress u_egress (
        .clk     (clk),
        .arst_n  (arst_n),
        .pkt_in  (link[NUM_TILES]),
        .rd_done (rd_done),
        .rd_data (rd_data),
        .rd_nack (rd_nack)
    );

endmodule

`default_nettype wire

// ==== glb_cfg_egress.sv ====
// end of the chain, turns read packets into the host read-done pulse, data and nack
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_egress (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  glb_cfg_pkg::cfg_pkt_t                  pkt_in,
    output logic                                   rd_done,
    output logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] rd_data,
    output logic                                   rd_nack
);

    import glb_cfg_pkg::*;

    logic is_rd;

    assign is_rd = (pkt_in.op == CFG_OP_RD);

    // writes and idles just drop out here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_done <= 1'b0;
            rd_data <= '0;
            rd_nack <= 1'b0;
        end else begin
            rd_done <= is_rd;   // single cycle, one per read packet
            if (is_rd) begin
                if (pkt_in.ack) begin
                    rd_data <= pkt_in.rd_data;
                    rd_nack <= 1'b0;
                end else begin
                    // nobody claimed it
                    rd_data <= '0;
                    rd_nack <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== glb_tile_cfg.sv ====
// per-tile config register bank, served from the chain and forwarded east one cycle later
`timescale 1ns/100ps
`default_nettype none

module glb_tile_cfg #(
    parameter int QUEUE_DEPTH = 2,
    parameter int TILE_ID     = 0
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  glb_cfg_pkg::cfg_pkt_t                    pkt_in,
    output glb_cfg_pkg::cfg_pkt_t                    pkt_out,
    input  logic [QUEUE_DEPTH-1:0]                   st_invalidate,
    input  logic [QUEUE_DEPTH-1:0]                   ld_invalidate,
    output glb_cfg_pkg::tile_ctrl_t                  tile_ctrl,
    output logic [3:0]                               latency,
    output glb_cfg_pkg::dma_header_t [QUEUE_DEPTH-1:0] st_header,
    output glb_cfg_pkg::dma_header_t [QUEUE_DEPTH-1:0] ld_header
);

    import glb_cfg_pkg::*;

    logic                      tile_hit;
    logic                      wr_hit;
    logic                      rd_hit;
    cfg_reg_e                  reg_id;
    logic                      hdr_sel;    // index in the dma header range
    logic [REG_ID_WIDTH-1:0]   hdr_off;    // [2] load, [1] queue, [0] words
    logic [CFG_DATA_WIDTH-1:0] rd_value;
    logic                      rd_mapped;
    logic [QUEUE_DEPTH-1:0]    st_validate;
    logic [QUEUE_DEPTH-1:0]    ld_validate;

    assign tile_hit = pkt_in.addr[CFG_ADDR_WIDTH-1 -: TILE_ID_WIDTH] == TILE_ID_WIDTH'(TILE_ID);
    assign wr_hit   = tile_hit && (pkt_in.op == CFG_OP_WR);
    assign rd_hit   = tile_hit && (pkt_in.op == CFG_OP_RD);

    assign reg_id  = cfg_reg_e'(pkt_in.addr[REG_ID_WIDTH-1:0]);
    assign hdr_sel = (reg_id >= REG_ST_ADDR_0) && (reg_id <= REG_LD_WORDS_1);
    assign hdr_off = pkt_in.addr[REG_ID_WIDTH-1:0] - REG_ID_WIDTH'(REG_ST_ADDR_0);

    // one bits only, zeros leave valid alone
    assign st_validate = (wr_hit && reg_id == REG_VALIDATE) ? pkt_in.wr_data[QUEUE_DEPTH-1:0] : '0;
    assign ld_validate = (wr_hit && reg_id == REG_VALIDATE) ? pkt_in.wr_data[2 +: QUEUE_DEPTH] : '0;

    // read mux, queues beyond QUEUE_DEPTH stay unmapped
    always_comb begin
        rd_value  = '0;
        rd_mapped = 1'b0;
        case (reg_id)
            REG_TILE_CTRL: begin
                rd_value  = CFG_DATA_WIDTH'(tile_ctrl);
                rd_mapped = 1'b1;
            end
            REG_LATENCY: begin
                rd_value  = CFG_DATA_WIDTH'(latency);
                rd_mapped = 1'b1;
            end
            REG_VALIDATE: begin
                for (int q = 0; q < QUEUE_DEPTH; q++) begin
                    rd_value[q]     = st_header[q].valid;
                    rd_value[2 + q] = ld_header[q].valid;
                end
                rd_mapped = 1'b1;
            end
            default: begin
                for (int q = 0; q < QUEUE_DEPTH; q++) begin
                    if (hdr_sel && int'(hdr_off[1]) == q) begin
                        rd_mapped = 1'b1;
                        case (hdr_off[2:0] & 3'b101)
                            3'b000:  rd_value = CFG_DATA_WIDTH'(st_header[q].start_addr);
                            3'b001:  rd_value = CFG_DATA_WIDTH'(st_header[q].num_words);
                            3'b100:  rd_value = CFG_DATA_WIDTH'(ld_header[q].start_addr);
                            default: rd_value = CFG_DATA_WIDTH'(ld_header[q].num_words);
                        endcase
                    end
                end
            end
        endcase
    end

    // register bank
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tile_ctrl <= '0;
            latency   <= '0;
            st_header <= '0;
            ld_header <= '0;
        end else begin
            if (wr_hit && reg_id == REG_TILE_CTRL) begin
                tile_ctrl <= tile_ctrl_t'(pkt_in.wr_data[$bits(tile_ctrl_t)-1:0]);
            end
            if (wr_hit && reg_id == REG_LATENCY) begin
                latency <= pkt_in.wr_data[3:0];
            end
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                if (wr_hit && hdr_sel && int'(hdr_off[1]) == q) begin
                    case (hdr_off[2:0] & 3'b101)
                        3'b000:  st_header[q].start_addr <= pkt_in.wr_data[GLB_ADDR_WIDTH-1:0];
                        3'b001:  st_header[q].num_words  <= pkt_in.wr_data[NUM_WORDS_WIDTH-1:0];
                        3'b100:  ld_header[q].start_addr <= pkt_in.wr_data[GLB_ADDR_WIDTH-1:0];
                        default: ld_header[q].num_words  <= pkt_in.wr_data[NUM_WORDS_WIDTH-1:0];
                    endcase
                end
                // hardware clear beats a validate in the same cycle
                st_header[q].valid <= (st_header[q].valid | st_validate[q]) & ~st_invalidate[q];
                ld_header[q].valid <= (ld_header[q].valid | ld_validate[q]) & ~ld_invalidate[q];
            end
        end
    end

    // forward east, merge read data on a hit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_out <= '0;
        end else begin
            pkt_out <= pkt_in;
            if (rd_hit && rd_mapped) begin
                pkt_out.rd_data <= rd_value;
                pkt_out.ack     <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== glb_cfg_ingress.sv ====
// host strobe capture, launches one request packet per cycle into chain link 0
`timescale 1ns/100ps
`default_nettype none

module glb_cfg_ingress (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                wr_en,
    input  logic                                rd_en,
    input  logic [glb_cfg_pkg::CFG_ADDR_WIDTH-1:0] addr,
    input  logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] wr_data,
    output glb_cfg_pkg::cfg_pkt_t               pkt_out
);

    import glb_cfg_pkg::*;

    cfg_op_e op_next;

    // host never raises both strobes together
    always_comb begin
        if (wr_en) begin
            op_next = CFG_OP_WR;
        end else if (rd_en) begin
            op_next = CFG_OP_RD;
        end else begin
            op_next = CFG_OP_IDLE;
        end
    end

    // fresh packet every cycle, idle when no strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_out <= '0;
        end else begin
            pkt_out.op      <= op_next;
            pkt_out.addr    <= addr;
            pkt_out.wr_data <= wr_data;
            pkt_out.rd_data <= '0;
            pkt_out.ack     <= 1'b0;   // no tile has seen it yet
        end
    end

endmodule

`default_nettype wire

// ==== glb_cfg_pkg.sv ====
// shared widths, opcode and register enums and chain structs, imported by every config block
`default_nettype none

package glb_cfg_pkg;

    // address is {tile, reg}
    localparam int TILE_ID_WIDTH   = 4;
    localparam int REG_ID_WIDTH    = 4;
    localparam int CFG_ADDR_WIDTH  = TILE_ID_WIDTH + REG_ID_WIDTH;
    localparam int CFG_DATA_WIDTH  = 32;

    localparam int GLB_ADDR_WIDTH  = 22;
    localparam int NUM_WORDS_WIDTH = 21;

    typedef enum logic [1:0] {
        CFG_OP_IDLE = 2'd0,
        CFG_OP_WR   = 2'd1,
        CFG_OP_RD   = 2'd2
    } cfg_op_e;

    // indexes 11 and up are unmapped
    typedef enum logic [REG_ID_WIDTH-1:0] {
        REG_TILE_CTRL  = 4'd0,
        REG_LATENCY    = 4'd1,
        REG_ST_ADDR_0  = 4'd2,
        REG_ST_WORDS_0 = 4'd3,
        REG_ST_ADDR_1  = 4'd4,
        REG_ST_WORDS_1 = 4'd5,
        REG_LD_ADDR_0  = 4'd6,
        REG_LD_WORDS_0 = 4'd7,
        REG_LD_ADDR_1  = 4'd8,
        REG_LD_WORDS_1 = 4'd9,
        REG_VALIDATE   = 4'd10
    } cfg_reg_e;

    // request packet moving west to east
    typedef struct packed {
        cfg_op_e                   op;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      ack;     // set by the serving tile
    } cfg_pkt_t;

    // last field sits at bit 0 of the ctrl word
    typedef struct packed {
        logic [1:0] st_dma_mode;
        logic [1:0] ld_dma_mode;
        logic [1:0] strm_f2g_mux;
        logic [1:0] strm_g2f_mux;
        logic       tile_connected;
    } tile_ctrl_t;

    // same layout for store and load queues
    typedef struct packed {
        logic                       valid;
        logic [GLB_ADDR_WIDTH-1:0]  start_addr;
        logic [NUM_WORDS_WIDTH-1:0] num_words;
    } dma_header_t;

endpackage

`default_nettype wire
